//--- hw/mem_op_pkg.sv
package mem_op_pkg;

  // core-side data path widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  strb_t;

  // load functions, signed variants extend the top bit
  typedef enum logic [2:0] {
    LD_B,
    LD_BU,
    LD_H,
    LD_HU,
    LD_W
  } load_func_e;

  typedef enum logic [1:0] {
    ST_B,
    ST_H,
    ST_W
  } store_func_e;

  typedef struct packed {
    addr_t      addr;
    load_func_e func;
  } load_req_t;

  typedef struct packed {
    addr_t       addr;
    word_t       data;
    store_func_e func;
  } store_req_t;

endpackage

//--- hw/axi_lite_pkg.sv
package axi_lite_pkg;

  // bus widths of the AXI4-Lite link
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  // only the two codes this slave ever answers with
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // AR and AW payload
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
  } axi_addr_t;

  // W payload
  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
  } axi_wdata_t;

  // R payload
  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    axi_resp_e             resp;
  } axi_rdata_t;

endpackage

//--- hw/lsu_load_path.sv
`timescale 1ns/100ps

module lsu_load_path
  import mem_op_pkg::*, axi_lite_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  // core load request
  input  logic       load_valid,
  input  load_req_t  load_req,
  output logic       load_ready,
  // core load response
  output logic       load_resp_valid,
  output word_t      load_data,
  output axi_resp_e  load_status,
  input  logic       load_resp_ready,
  // read address channel
  output logic       ar_valid,
  output axi_addr_t  ar,
  input  logic       ar_ready,
  // read data channel
  input  logic       r_valid,
  input  axi_rdata_t r,
  output logic       r_ready
);

  logic [1:0] offset_q;
  load_func_e func_q;
  word_t      shifted;

  // request goes straight through to AR, word aligned
  assign ar_valid = load_valid;
  assign ar.addr  = {load_req.addr[31:2], 2'b00};
  assign load_ready = ar_ready;

  // keep what is needed to format the returning word
  always_ff @(posedge clk) begin
    if (!rstn) begin
      offset_q <= 2'b00;
      func_q   <= LD_W;
    end else if (load_valid && ar_ready) begin
      offset_q <= load_req.addr[1:0];
      func_q   <= load_req.func;
    end
  end

  // bytes past the word end come in as zero
  assign shifted = r.data >> {offset_q, 3'b000};

  always_comb begin
    case (func_q)
      LD_B:    load_data = {{24{shifted[7]}}, shifted[7:0]};
      LD_BU:   load_data = {24'b0, shifted[7:0]};
      LD_H:    load_data = {{16{shifted[15]}}, shifted[15:0]};
      LD_HU:   load_data = {16'b0, shifted[15:0]};
      default: load_data = shifted;
    endcase
  end

  // response follows R in the same cycle
  assign load_resp_valid = r_valid;
  assign load_status     = r.resp;
  assign r_ready         = load_resp_ready;

endmodule

//--- hw/lsu_store_path.sv
`timescale 1ns/100ps

module lsu_store_path
  import mem_op_pkg::*, axi_lite_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  // core store request
  input  logic       store_valid,
  input  store_req_t store_req,
  output logic       store_ready,
  // core store response
  output logic       store_resp_valid,
  output axi_resp_e  store_status,
  input  logic       store_resp_ready,
  // write address channel
  output logic       aw_valid,
  output axi_addr_t  aw,
  input  logic       aw_ready,
  // write data channel
  output logic       w_valid,
  output axi_wdata_t w,
  input  logic       w_ready,
  // write response channel
  input  logic       b_valid,
  input  axi_resp_e  b_resp,
  output logic       b_ready
);

  logic [1:0] offset;
  strb_t      lanes;
  word_t      data_shifted;
  strb_t      strb_shifted;
  // set while that channel still has to send the current store
  logic       aw_todo;
  logic       w_todo;

  assign offset = store_req.addr[1:0];

  always_comb begin
    case (store_req.func)
      ST_B:    lanes = 4'b0001;
      ST_H:    lanes = 4'b0011;
      default: lanes = 4'b1111;
    endcase
  end

  // lanes that slide past bit 3 are dropped
  assign data_shifted = store_req.data << {offset, 3'b000};
  assign strb_shifted = lanes << offset;

  assign aw.addr = {store_req.addr[31:2], 2'b00};
  assign w.data  = data_shifted;
  assign w.strb  = strb_shifted;

  assign aw_valid = store_valid && aw_todo;
  assign w_valid  = store_valid && w_todo;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_todo <= 1'b1;
      w_todo  <= 1'b1;
    end else if (b_valid && b_ready) begin
      aw_todo <= 1'b1;
      w_todo  <= 1'b1;
    end else begin
      if (aw_valid && aw_ready) begin
        aw_todo <= 1'b0;
      end
      if (w_valid && w_ready) begin
        w_todo <= 1'b0;
      end
    end
  end

  // accept once both halves are covered, but not again while waiting for B
  assign store_ready = (aw_todo || w_todo)
                    && (!aw_todo || aw_ready)
                    && (!w_todo || w_ready);

  assign store_resp_valid = b_valid;
  assign store_status     = b_resp;
  assign b_ready          = store_resp_ready;

endmodule

//--- hw/axi_lite_ram.sv
`timescale 1ns/100ps

module axi_lite_ram
  import axi_lite_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic       clk,
  input  logic       rstn,
  // read side
  input  logic       ar_valid,
  input  axi_addr_t  ar,
  output logic       ar_ready,
  output logic       r_valid,
  output axi_rdata_t r,
  input  logic       r_ready,
  // write side
  input  logic       aw_valid,
  input  axi_addr_t  aw,
  output logic       aw_ready,
  input  logic       w_valid,
  input  axi_wdata_t w,
  output logic       w_ready,
  output logic       b_valid,
  output axi_resp_e  b_resp,
  input  logic       b_ready
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int WORD_IDX_W = AXI_ADDR_W - 2;

  typedef enum logic [1:0] {
    W_IDLE,
    W_HAVE_ADDR,
    W_HAVE_DATA,
    W_RESP
  } wr_state_e;

  logic [AXI_DATA_W-1:0] mem [MEM_WORDS];

  logic [WORD_IDX_W-1:0] ar_word;
  logic                  ar_in_range;
  logic                  rvalid_q;
  axi_rdata_t            rdata_q;

  wr_state_e             wr_state;
  axi_addr_t             aw_q;
  axi_wdata_t            w_q;
  logic [WORD_IDX_W-1:0] aw_word;
  logic                  aw_in_range;
  logic                  aw_hs;
  logic                  w_hs;

  // read channel, one cycle to R
  assign ar_word     = ar.addr[AXI_ADDR_W-1:2];
  assign ar_in_range = ar_word < WORD_IDX_W'(MEM_WORDS);
  assign ar_ready    = !rvalid_q;
  assign r_valid     = rvalid_q;
  assign r           = rdata_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rvalid_q <= 1'b0;
    end else if (ar_valid && ar_ready) begin
      rvalid_q <= 1'b1;
    end else if (r_valid && r_ready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready) begin
      rdata_q.data <= ar_in_range ? mem[ar_word[IDX_W-1:0]] : '0;
      rdata_q.resp <= ar_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // write channel, AW and W may arrive in either order
  assign aw_ready = (wr_state == W_IDLE) || (wr_state == W_HAVE_DATA);
  assign w_ready  = (wr_state == W_IDLE) || (wr_state == W_HAVE_ADDR);
  assign aw_hs    = aw_valid && aw_ready;
  assign w_hs     = w_valid && w_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_state <= W_IDLE;
    end else begin
      case (wr_state)
        W_IDLE: begin
          if (aw_hs && w_hs) begin
            wr_state <= W_RESP;
          end else if (aw_hs) begin
            wr_state <= W_HAVE_ADDR;
          end else if (w_hs) begin
            wr_state <= W_HAVE_DATA;
          end
        end
        W_HAVE_ADDR: if (w_hs) wr_state <= W_RESP;
        W_HAVE_DATA: if (aw_hs) wr_state <= W_RESP;
        default:     if (b_ready) wr_state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_q <= aw;
    end
    if (w_hs) begin
      w_q <= w;
    end
  end

  assign aw_word     = aw_q.addr[AXI_ADDR_W-1:2];
  assign aw_in_range = aw_word < WORD_IDX_W'(MEM_WORDS);

  // rewriting the held bytes while B waits leaves the word unchanged
  always_ff @(posedge clk) begin
    if (wr_state == W_RESP && aw_in_range) begin
      for (int i = 0; i < AXI_STRB_W; i++) begin
        if (w_q.strb[i]) begin
          mem[aw_word[IDX_W-1:0]][8*i +: 8] <= w_q.data[8*i +: 8];
        end
      end
    end
  end

  assign b_valid = (wr_state == W_RESP);
  assign b_resp  = aw_in_range ? RESP_OKAY : RESP_SLVERR;

endmodule

//--- hw/lsu_axi_top.sv
`timescale 1ns/100ps

module lsu_axi_top
  import mem_op_pkg::*, axi_lite_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic       clk,
  input  logic       rstn,
  // loads
  input  logic       load_valid,
  input  load_req_t  load_req,
  output logic       load_ready,
  output logic       load_resp_valid,
  output word_t      load_data,
  output axi_resp_e  load_status,
  input  logic       load_resp_ready,
  // stores
  input  logic       store_valid,
  input  store_req_t store_req,
  output logic       store_ready,
  output logic       store_resp_valid,
  output axi_resp_e  store_status,
  input  logic       store_resp_ready
);

  // AXI4-Lite link between the LSU and the memory
  logic       ar_valid;
  axi_addr_t  ar;
  logic       ar_ready;
  logic       r_valid;
  axi_rdata_t r;
  logic       r_ready;
  logic       aw_valid;
  axi_addr_t  aw;
  logic       aw_ready;
  logic       w_valid;
  axi_wdata_t w;
  logic       w_ready;
  logic       b_valid;
  axi_resp_e  b_resp;
  logic       b_ready;

  lsu_load_path u_load_path (
    .clk             (clk),
    .rstn            (rstn),
    .load_valid      (load_valid),
    .load_req        (load_req),
    .load_ready      (load_ready),
    .load_resp_valid (load_resp_valid),
    .load_data       (load_data),
    .load_status     (load_status),
    .load_resp_ready (load_resp_ready),
    .ar_valid        (ar_valid),
    .ar              (ar),
    .ar_ready        (ar_ready),
    .r_valid         (r_valid),
    .r               (r),
    .r_ready         (r_ready)
  );

  lsu_store_path u_store_path (
    .clk              (clk),
    .rstn             (rstn),
    .store_valid      (store_valid),
    .store_req        (store_req),
    .store_ready      (store_ready),
    .store_resp_valid (store_resp_valid),
    .store_status     (store_status),
    .store_resp_ready (store_resp_ready),
    .aw_valid         (aw_valid),
    .aw               (aw),
    .aw_ready         (aw_ready),
    .w_valid          (w_valid),
    .w                (w),
    .w_ready          (w_ready),
    .b_valid          (b_valid),
    .b_resp           (b_resp),
    .b_ready          (b_ready)
  );

  axi_lite_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ram (
    .clk      (clk),
    .rstn     (rstn),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r        (r),
    .r_ready  (r_ready),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b_resp   (b_resp),
    .b_ready  (b_ready)
  );

endmodule

//--- verification/tb_lsu_axi.sv
`timescale 1ns/100ps

module tb_lsu_axi
  import mem_op_pkg::*, axi_lite_pkg::*;
;

  localparam int MEM_WORDS = 256;
  // transactions per test for the watchdog limit
  localparam int N_T1  = 2 * 8;
  localparam int N_T2  = 3 * 2 * 4;
  localparam int N_T3  = 2 * (1 + 4 * 5);
  localparam int N_T4  = 4 * 4;
  localparam int N_T5  = 300;
  localparam int N_TXN = N_T1 + N_T2 + N_T3 + N_T4 + N_T5;

  logic       clk;
  logic       rstn;
  logic       load_valid;
  load_req_t  load_req;
  logic       load_ready;
  logic       load_resp_valid;
  word_t      load_data;
  axi_resp_e  load_status;
  logic       load_resp_ready;
  logic       store_valid;
  store_req_t store_req;
  logic       store_ready;
  logic       store_resp_valid;
  axi_resp_e  store_status;
  logic       store_resp_ready;

  // shadow memory and the words known to be fully written
  logic [7:0] shadow [4*MEM_WORDS];
  bit         written [MEM_WORDS];
  int         written_q [$];

  // outstanding requests in issue order
  word_t      ld_exp_data [$];
  axi_resp_e  ld_exp_status [$];
  store_req_t st_exp_req [$];

  logic       load_took;
  logic       store_took;
  int         load_sent;
  int         load_done;
  int         store_sent;
  int         store_done;
  string      test_name;

  lsu_axi_top #(
    .MEM_WORDS (MEM_WORDS)
  ) dut (
    .clk              (clk),
    .rstn             (rstn),
    .load_valid       (load_valid),
    .load_req         (load_req),
    .load_ready       (load_ready),
    .load_resp_valid  (load_resp_valid),
    .load_data        (load_data),
    .load_status      (load_status),
    .load_resp_ready  (load_resp_ready),
    .store_valid      (store_valid),
    .store_req        (store_req),
    .store_ready      (store_ready),
    .store_resp_valid (store_resp_valid),
    .store_status     (store_status),
    .store_resp_ready (store_resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic bit in_range(input addr_t addr);
    return addr[31:2] < 30'(MEM_WORDS);
  endfunction

  function automatic axi_resp_e expected_status(input addr_t addr);
    if (in_range(addr)) begin
      return RESP_OKAY;
    end
    return RESP_SLVERR;
  endfunction

  // reference load fetches the word, shifts right by the offset and extends
  function automatic word_t model_load(input addr_t addr, input load_func_e func);
    word_t raw;
    word_t moved;
    raw = '0;
    if (in_range(addr)) begin
      for (int i = 0; i < 4; i++) begin
        raw[8*i +: 8] = shadow[4 * int'(addr[31:2]) + i];
      end
    end
    moved = raw >> (8 * addr[1:0]);
    case (func)
      LD_B:    return word_t'(moved[7:0]) - (moved[7] ? 32'd256 : 32'd0);
      LD_BU:   return word_t'(moved[7:0]);
      LD_H:    return word_t'(moved[15:0]) - (moved[15] ? 32'd65536 : 32'd0);
      LD_HU:   return word_t'(moved[15:0]);
      default: return moved;
    endcase
  endfunction

  function automatic void model_store(input store_req_t req);
    int nbytes;
    int lane;
    nbytes = (req.func == ST_B) ? 1 : (req.func == ST_H) ? 2 : 4;
    if (in_range(req.addr)) begin
      for (int k = 0; k < nbytes; k++) begin
        lane = int'(req.addr[1:0]) + k;
        // bytes past the word end are dropped
        if (lane < 4) begin
          shadow[4 * int'(req.addr[31:2]) + lane] = req.data[8*k +: 8];
        end
      end
    end
  endfunction

  task automatic check_data(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "load data mismatch");
    end
  endtask

  task automatic check_status(input string name, input axi_resp_e exp, input axi_resp_e act);
    if (act !== exp) begin
      $display("** Error: %s expected %s actual %s", name, exp.name(), act.name());
      $display("TB FAILED");
      $fatal(1, "response status mismatch");
    end
  endtask

  task automatic retire_load();
    if (ld_exp_data.size() == 0) begin
      $display("a load response arrived with no load outstanding");
      $display("TB FAILED");
      $fatal(1, "unexpected load response");
    end else begin
      check_data(test_name, ld_exp_data.pop_front(), load_data);
      check_status(test_name, ld_exp_status.pop_front(), load_status);
    end
  endtask

  task automatic retire_store();
    store_req_t req;
    int         idx;
    if (st_exp_req.size() == 0) begin
      $display("a store response arrived with no store outstanding");
      $display("TB FAILED");
      $fatal(1, "unexpected store response");
    end else begin
      req = st_exp_req.pop_front();
      check_status(test_name, expected_status(req.addr), store_status);
      model_store(req);
      // only a whole-word store makes a word safe to load at random
      if (in_range(req.addr) && req.func == ST_W && req.addr[1:0] == 2'b00) begin
        idx = int'(req.addr[31:2]);
        if (!written[idx]) begin
          written[idx] = 1'b1;
          written_q.push_back(idx);
        end
      end
    end
  endtask

  // response checker sampled on the rising edge
  always @(posedge clk) begin
    if (!rstn) begin
      load_took  <= 1'b0;
      store_took <= 1'b0;
      load_sent  <= 0;
      load_done  <= 0;
      store_sent <= 0;
      store_done <= 0;
    end else begin
      load_took  <= load_valid && load_ready;
      store_took <= store_valid && store_ready;
      if (load_resp_valid && load_resp_ready) begin
        retire_load();
        load_done <= load_done + 1;
      end
      if (store_resp_valid && store_resp_ready) begin
        retire_store();
        store_done <= store_done + 1;
      end
      if (load_valid && load_ready) begin
        ld_exp_data.push_back(model_load(load_req.addr, load_req.func));
        ld_exp_status.push_back(expected_status(load_req.addr));
        load_sent <= load_sent + 1;
      end
      if (store_valid && store_ready) begin
        st_exp_req.push_back(store_req);
        store_sent <= store_sent + 1;
      end
    end
  end

  task automatic do_store(input addr_t addr, input word_t data, input store_func_e func);
    @(negedge clk);
    store_req.addr = addr;
    store_req.data = data;
    store_req.func = func;
    store_valid = 1'b1;
    do @(negedge clk); while (!store_took);
    store_valid = 1'b0;
    while (store_done != store_sent) @(negedge clk);
  endtask

  task automatic do_load(input addr_t addr, input load_func_e func);
    @(negedge clk);
    load_req.addr = addr;
    load_req.func = func;
    load_valid = 1'b1;
    do @(negedge clk); while (!load_took);
    load_valid = 1'b0;
    while (load_done != load_sent) @(negedge clk);
  endtask

  // both channels at once with response back-pressure
  task automatic random_mix(input int total);
    int issued;
    int st_word;
    int ld_word;
    bit st_busy;
    issued = 0;
    st_word = -1;
    while (issued < total || load_valid || store_valid
           || load_done != load_sent || store_done != store_sent) begin
      @(negedge clk);
      load_resp_ready = ($urandom_range(0, 3) != 0);
      store_resp_ready = ($urandom_range(0, 3) != 0);
      if (load_took) load_valid = 1'b0;
      if (store_took) store_valid = 1'b0;
      // one store at a time and never on a word a pending load still reads
      if (issued < total && !store_valid && store_done == store_sent
          && $urandom_range(0, 1) == 1) begin
        st_word = $urandom_range(0, MEM_WORDS - 1);
        if (!load_valid || st_word != int'(load_req.addr[31:2])) begin
          store_req.addr = addr_t'(4 * st_word + $urandom_range(0, 3));
          store_req.data = $urandom();
          store_req.func = store_func_e'($urandom_range(0, 2));
          store_valid = 1'b1;
          issued++;
        end
      end
      st_busy = store_valid || store_done != store_sent;
      if (issued < total && !load_valid && $urandom_range(0, 1) == 1) begin
        ld_word = written_q[$urandom_range(0, written_q.size() - 1)];
        if (!st_busy || ld_word != st_word) begin
          load_req.addr = addr_t'(4 * ld_word + $urandom_range(0, 3));
          load_req.func = load_func_e'($urandom_range(0, 4));
          load_valid = 1'b1;
          issued++;
        end
      end
    end
    load_resp_ready = 1'b1;
    store_resp_ready = 1'b1;
  endtask

  function automatic addr_t far_addr(input int i);
    case (i)
      0:       return 32'h0000_0400;
      1:       return 32'h0000_0401;
      2:       return 32'h0001_0008;
      default: return 32'hFFFF_FFFC;
    endcase
  endfunction

  initial begin
    int    word_idx;
    word_t pattern;
    addr_t oor;
    addr_t alias_addr;
    void'($urandom(8));
    rstn = 1'b0;
    load_valid = 1'b0;
    load_req = '0;
    load_resp_ready = 1'b1;
    store_valid = 1'b0;
    store_req = '0;
    store_resp_ready = 1'b1;
    test_name = "reset";
    repeat (3) @(negedge clk);
    rstn = 1'b1;

    test_name = "word_store_load";
    for (int i = 0; i < 8; i++) begin
      word_idx = (i * 37) % MEM_WORDS;
      do_store(addr_t'(4 * word_idx), $urandom(), ST_W);
      do_load(addr_t'(4 * word_idx), LD_W);
    end

    test_name = "byte_half_lanes";
    for (int off = 0; off < 4; off++) begin
      for (int f = 0; f < 2; f++) begin
        do_store(addr_t'(40), 32'h1122_3344, ST_W);
        do_store(addr_t'(40 + off), $urandom(), store_func_e'(f));
        do_load(addr_t'(40), LD_W);
      end
    end

    // first pattern has every byte and half negative
    test_name = "load_extend";
    for (int p = 0; p < 2; p++) begin
      pattern = (p == 0) ? 32'h8F80_F7A5 : 32'h7F01_7E30;
      do_store(addr_t'(80), pattern, ST_W);
      for (int off = 0; off < 4; off++) begin
        for (int lf = 0; lf < 5; lf++) begin
          do_load(addr_t'(80 + off), load_func_e'(lf));
        end
      end
    end

    // the word that the low index bits alias must stay unchanged
    test_name = "out_of_range";
    for (int i = 0; i < 4; i++) begin
      oor = far_addr(i);
      alias_addr = addr_t'({oor[9:2], 2'b00});
      do_store(alias_addr, $urandom(), ST_W);
      do_store(oor, 32'hDEAD_BEEF, ST_W);
      do_load(oor, LD_W);
      do_load(alias_addr, LD_W);
    end

    test_name = "random_mix";
    random_mix(N_T5);

    $display("TB PASSED");
    $finish;
  end

  // watchdog
  initial begin
    repeat (200 * N_TXN) @(posedge clk);
    $display("watchdog expired in test %s, a response never arrived", test_name);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- lsu_axi.f
hw/mem_op_pkg.sv
hw/axi_lite_pkg.sv
hw/lsu_load_path.sv
hw/lsu_store_path.sv
hw/axi_lite_ram.sv
hw/lsu_axi_top.sv
verification/tb_lsu_axi.sv

//--- run_sim.sh
#!/bin/sh
# build and run the LSU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module tb_lsu_axi \
  -f lsu_axi.f \
  -o tb_lsu_axi

./obj_dir/tb_lsu_axi
